// File: Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module sched_tb \
		-Mdir $(OBJ_DIR) -o sim_sched
	./$(OBJ_DIR)/sim_sched | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+logic
logic/sched_pkg.sv
logic/wakeup_match.sv
logic/sched_entry.sv
logic/sched_select.sv
logic/exec_timer.sv
logic/sched_top.sv
test/sched_chk.sv
test/sched_tb.sv

// File: logic/exec_timer.sv
`include "sched_params.svh"

module exec_timer (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic [`SCHED_ENTRIES-1:0] i_pick_vec,
  input  sched_pkg::op_t            i_pick_op,
  input  logic [`SCHED_ENTRIES-1:0] i_dead,
  output logic [`SCHED_ENTRIES-1:0] o_done_vec
);

  import sched_pkg::*;

  logic [`SCHED_ENTRIES-1:0]             r_busy;
  logic [`SCHED_ENTRIES-1:0][`LAT_W-1:0] r_cnt;
  logic [`SCHED_ENTRIES-1:0]             w_expired;
  logic [`LAT_W-1:0]                     w_load;

  // counter runs from L-1 down to zero, strobe fires on zero
  assign w_load = (i_pick_op == OP_MUL) ? `LAT_W'(`LAT_MUL - 1) :
                                          `LAT_W'(`LAT_ALU - 1);

  always_comb begin
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      w_expired[i] = r_busy[i] & (r_cnt[i] == '0) & ~i_dead[i];
    end
  end

  // one strobe per cycle, lowest index first
  assign o_done_vec = w_expired & -w_expired;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= '0;
      r_cnt  <= '0;
    end else begin
      for (int i = 0; i < `SCHED_ENTRIES; i++) begin
        if (i_dead[i]) begin
          // flushed op, no stale strobe for the reused slot
          r_busy[i] <= 1'b0;
          r_cnt[i]  <= '0;
        end else if (i_pick_vec[i]) begin
          r_busy[i] <= 1'b1;
          r_cnt[i]  <= w_load;
        end else if (o_done_vec[i]) begin
          r_busy[i] <= 1'b0;
        end else if (r_busy[i] && r_cnt[i] != '0) begin
          r_cnt[i] <= r_cnt[i] - 1'b1;
        end
        // expired but lost arbitration: hold at zero
      end
    end
  end

endmodule

// File: logic/sched_entry.sv
`include "sched_params.svh"

module sched_entry (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_put,
  input  sched_pkg::op_t       i_put_op,
  input  logic                 i_put_rs1_valid,
  input  logic [`RNID_W-1:0]   i_put_rs1_rnid,
  input  logic                 i_put_rs2_valid,
  input  logic [`RNID_W-1:0]   i_put_rs2_rnid,
  input  logic [`RNID_W-1:0]   i_put_rd_rnid,
  input  logic [`CMT_ID_W-1:0] i_put_cmt_id,

  input  logic                 i_wb_valid,
  input  logic [`RNID_W-1:0]   i_wb_rnid,
  input  logic                 i_ext_wr_valid,
  input  logic [`RNID_W-1:0]   i_ext_wr_rnid,

  input  logic                 i_picked,
  input  logic                 i_exec_done,

  input  logic                 i_commit_valid,
  input  logic                 i_commit_flush,
  input  logic                 i_commit_all_dead,
  input  logic [`CMT_ID_W-1:0] i_commit_cmt_id,

  output logic                 o_free,
  output logic                 o_ready,
  output logic                 o_issued,
  output logic                 o_done,
  output logic                 o_dead,
  output logic                 o_dead_done,
  output sched_pkg::op_t       o_op,
  output logic [`RNID_W-1:0]   o_rd_rnid,
  output logic [`CMT_ID_W-1:0] o_cmt_id,
  output logic                 o_except
);

  import sched_pkg::*;

  sched_state_t          r_state;
  op_t                   r_op;
  logic                  r_rs1_valid;
  logic [`RNID_W-1:0]    r_rs1_rnid;
  logic                  r_rs1_ready;
  logic                  r_rs2_valid;
  logic [`RNID_W-1:0]    r_rs2_rnid;
  logic                  r_rs2_ready;
  logic [`RNID_W-1:0]    r_rd_rnid;
  logic [`CMT_ID_W-1:0]  r_cmt_id;
  logic                  r_except;

  logic [`RNID_W-1:0]    w_rs1_rnid;
  logic [`RNID_W-1:0]    w_rs2_rnid;
  logic                  w_rs1_hit;
  logic                  w_rs2_hit;
  logic                  w_rs1_ready;
  logic                  w_rs2_ready;
  logic                  w_flush;
  logic                  w_dead_clear;

  // match the incoming tags during the put cycle
  assign w_rs1_rnid = i_put ? i_put_rs1_rnid : r_rs1_rnid;
  assign w_rs2_rnid = i_put ? i_put_rs2_rnid : r_rs2_rnid;

  wakeup_match u_rs1_match (
    .i_rnid         (w_rs1_rnid),
    .i_wb_valid     (i_wb_valid),
    .i_wb_rnid      (i_wb_rnid),
    .i_ext_wr_valid (i_ext_wr_valid),
    .i_ext_wr_rnid  (i_ext_wr_rnid),
    .o_hit          (w_rs1_hit)
  );

  wakeup_match u_rs2_match (
    .i_rnid         (w_rs2_rnid),
    .i_wb_valid     (i_wb_valid),
    .i_wb_rnid      (i_wb_rnid),
    .i_ext_wr_valid (i_ext_wr_valid),
    .i_ext_wr_rnid  (i_ext_wr_rnid),
    .o_hit          (w_rs2_hit)
  );

  assign w_rs1_ready = r_rs1_ready | w_rs1_hit;
  assign w_rs2_ready = r_rs2_ready | w_rs2_hit;

  assign w_flush = i_commit_valid & i_commit_flush & ~i_commit_all_dead &
                   (r_state != INIT);
  assign w_dead_clear = i_commit_valid & i_commit_all_dead &
                        (i_commit_cmt_id == r_cmt_id) & (r_state == DEAD);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else if (w_flush) begin
      r_state <= DEAD;  // flush beats everything
    end else begin
      case (r_state)
        INIT:    if (i_put) r_state <= WAIT;
        WAIT:    if (o_ready && i_picked) r_state <= ISSUED;
        ISSUED:  if (i_exec_done) r_state <= DONE;
        DONE:    r_state <= INIT;
        DEAD:    if (w_dead_clear) r_state <= INIT;
        default: r_state <= INIT;
      endcase
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    if (r_state == INIT && i_put) begin
      r_op        <= i_put_op;
      r_rs1_valid <= i_put_rs1_valid;
      r_rs1_rnid  <= i_put_rs1_rnid;
      r_rs1_ready <= w_rs1_hit;  // write-back in the put cycle counts
      r_rs2_valid <= i_put_rs2_valid;
      r_rs2_rnid  <= i_put_rs2_rnid;
      r_rs2_ready <= w_rs2_hit;
      r_rd_rnid   <= i_put_rd_rnid;
      r_cmt_id    <= i_put_cmt_id;
      r_except    <= 1'b0;
    end else if (r_state == WAIT) begin
      r_rs1_ready <= w_rs1_ready;
      r_rs2_ready <= w_rs2_ready;
    end else if (r_state == ISSUED && i_exec_done) begin
      r_except <= (r_op == OP_TRAP);
    end
  end

  assign o_free      = (r_state == INIT);
  assign o_ready     = (r_state == WAIT) &
                       (~r_rs1_valid | w_rs1_ready) &
                       (~r_rs2_valid | w_rs2_ready);
  assign o_issued    = (r_state == ISSUED);
  assign o_done      = (r_state == DONE) & ~w_flush;
  assign o_dead      = (r_state == DEAD);
  assign o_dead_done = w_dead_clear;
  assign o_op        = r_op;
  assign o_rd_rnid   = r_rd_rnid;
  assign o_cmt_id    = r_cmt_id;
  assign o_except    = r_except;

endmodule

// File: logic/sched_params.svh
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// scheduler depth
`define SCHED_ENTRIES 4

// renamed register tag and commit id widths
`define RNID_W 5
`define CMT_ID_W 4

// execution latencies in cycles
`define LAT_ALU 1
`define LAT_MUL 3

// countdown width, must hold LAT_MUL - 1
`define LAT_W 2

`endif

// File: logic/sched_pkg.sv
package sched_pkg;

  // per-entry scheduler state
  typedef enum logic [2:0] {
    INIT,    // free slot
    WAIT,    // waiting on sources or pick
    ISSUED,  // in the exec pipe
    DONE,    // one cycle, broadcasts its tag
    DEAD     // flushed, waits for all-dead commit
  } sched_state_t;

  // micro-op opcodes
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MUL,   // long latency
    OP_TRAP   // raises exception at completion
  } op_t;

endpackage

// File: logic/sched_select.sv
`include "sched_params.svh"

module sched_select (
  input  logic                                        i_put,
  input  logic [`SCHED_ENTRIES-1:0]                   i_free,
  input  logic [`SCHED_ENTRIES-1:0]                   i_ready,
  input  logic [`SCHED_ENTRIES-1:0]                   i_done,
  input  logic [`SCHED_ENTRIES-1:0]                   i_dead_done,
  input  sched_pkg::op_t [`SCHED_ENTRIES-1:0]         i_op,
  input  logic [`SCHED_ENTRIES-1:0][`RNID_W-1:0]      i_rd_rnid,
  input  logic [`SCHED_ENTRIES-1:0][`CMT_ID_W-1:0]    i_cmt_id,
  input  logic [`SCHED_ENTRIES-1:0]                   i_except,

  output logic [`SCHED_ENTRIES-1:0]                   o_put_vec,
  output logic [`SCHED_ENTRIES-1:0]                   o_pick_vec,
  output logic                                        o_full,
  output logic                                        o_issue_valid,
  output sched_pkg::op_t                              o_issue_op,
  output logic [`RNID_W-1:0]                          o_issue_rd_rnid,
  output logic                                        o_wb_valid,
  output logic [`RNID_W-1:0]                          o_wb_rnid,
  output logic                                        o_done_valid,
  output logic [`CMT_ID_W-1:0]                        o_done_cmt_id,
  output logic                                        o_done_except,
  output logic                                        o_dead_done,
  output logic [`CMT_ID_W-1:0]                        o_dead_cmt_id
);

  import sched_pkg::*;

  assign o_full = ~|i_free;

  // lowest set bit wins
  assign o_put_vec  = (i_put & ~o_full) ? (i_free & -i_free) : '0;
  assign o_pick_vec = i_ready & -i_ready;

  assign o_issue_valid = |i_ready;
  assign o_wb_valid    = |i_done;    // timer keeps this one-hot
  assign o_done_valid  = o_wb_valid;
  assign o_dead_done   = |i_dead_done;

  always_comb begin
    o_issue_op      = OP_ADD;
    o_issue_rd_rnid = '0;
    o_wb_rnid       = '0;
    o_done_cmt_id   = '0;
    o_done_except   = 1'b0;
    o_dead_cmt_id   = '0;
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      if (o_pick_vec[i]) begin
        o_issue_op      = i_op[i];
        o_issue_rd_rnid = i_rd_rnid[i];
      end
      if (i_done[i]) begin
        o_wb_rnid     = i_rd_rnid[i];
        o_done_cmt_id = i_cmt_id[i];
        o_done_except = i_except[i];
      end
      if (i_dead_done[i]) o_dead_cmt_id = i_cmt_id[i];
    end
  end

endmodule

// File: logic/sched_top.sv
`include "sched_params.svh"

module sched_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  input  logic                 i_put,
  input  sched_pkg::op_t       i_put_op,
  input  logic                 i_put_rs1_valid,
  input  logic [`RNID_W-1:0]   i_put_rs1_rnid,
  input  logic                 i_put_rs2_valid,
  input  logic [`RNID_W-1:0]   i_put_rs2_rnid,
  input  logic [`RNID_W-1:0]   i_put_rd_rnid,
  input  logic [`CMT_ID_W-1:0] i_put_cmt_id,

  input  logic                 i_ext_wr_valid,
  input  logic [`RNID_W-1:0]   i_ext_wr_rnid,

  input  logic                 i_commit_valid,
  input  logic                 i_commit_flush,
  input  logic                 i_commit_all_dead,
  input  logic [`CMT_ID_W-1:0] i_commit_cmt_id,

  output logic                 o_issue_valid,
  output sched_pkg::op_t       o_issue_op,
  output logic [`RNID_W-1:0]   o_issue_rd_rnid,
  output logic                 o_done_valid,
  output logic [`CMT_ID_W-1:0] o_done_cmt_id,
  output logic                 o_done_except,
  output logic                 o_dead_done,
  output logic [`CMT_ID_W-1:0] o_dead_cmt_id,
  output logic                 o_full
);

  import sched_pkg::*;

  logic [`SCHED_ENTRIES-1:0]                w_put_vec;
  logic [`SCHED_ENTRIES-1:0]                w_pick_vec;
  logic [`SCHED_ENTRIES-1:0]                w_exec_done_vec;
  logic [`SCHED_ENTRIES-1:0]                w_free;
  logic [`SCHED_ENTRIES-1:0]                w_ready;
  logic [`SCHED_ENTRIES-1:0]                w_issued;  // observed by the checker
  logic [`SCHED_ENTRIES-1:0]                w_done;
  logic [`SCHED_ENTRIES-1:0]                w_dead;
  logic [`SCHED_ENTRIES-1:0]                w_dead_done;
  op_t  [`SCHED_ENTRIES-1:0]                w_op;
  logic [`SCHED_ENTRIES-1:0][`RNID_W-1:0]   w_rd_rnid;
  logic [`SCHED_ENTRIES-1:0][`CMT_ID_W-1:0] w_cmt_id;
  logic [`SCHED_ENTRIES-1:0]                w_except;
  logic                                     w_wb_valid;
  logic [`RNID_W-1:0]                       w_wb_rnid;

  for (genvar g = 0; g < `SCHED_ENTRIES; g++) begin : g_entry
    sched_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_put             (w_put_vec[g]),
      .i_put_op          (i_put_op),
      .i_put_rs1_valid   (i_put_rs1_valid),
      .i_put_rs1_rnid    (i_put_rs1_rnid),
      .i_put_rs2_valid   (i_put_rs2_valid),
      .i_put_rs2_rnid    (i_put_rs2_rnid),
      .i_put_rd_rnid     (i_put_rd_rnid),
      .i_put_cmt_id      (i_put_cmt_id),
      .i_wb_valid        (w_wb_valid),
      .i_wb_rnid         (w_wb_rnid),
      .i_ext_wr_valid    (i_ext_wr_valid),
      .i_ext_wr_rnid     (i_ext_wr_rnid),
      .i_picked          (w_pick_vec[g]),
      .i_exec_done       (w_exec_done_vec[g]),
      .i_commit_valid    (i_commit_valid),
      .i_commit_flush    (i_commit_flush),
      .i_commit_all_dead (i_commit_all_dead),
      .i_commit_cmt_id   (i_commit_cmt_id),
      .o_free            (w_free[g]),
      .o_ready           (w_ready[g]),
      .o_issued          (w_issued[g]),
      .o_done            (w_done[g]),
      .o_dead            (w_dead[g]),
      .o_dead_done       (w_dead_done[g]),
      .o_op              (w_op[g]),
      .o_rd_rnid         (w_rd_rnid[g]),
      .o_cmt_id          (w_cmt_id[g]),
      .o_except          (w_except[g])
    );
  end

  sched_select u_select (
    .i_put           (i_put),
    .i_free          (w_free),
    .i_ready         (w_ready),
    .i_done          (w_done),
    .i_dead_done     (w_dead_done),
    .i_op            (w_op),
    .i_rd_rnid       (w_rd_rnid),
    .i_cmt_id        (w_cmt_id),
    .i_except        (w_except),
    .o_put_vec       (w_put_vec),
    .o_pick_vec      (w_pick_vec),
    .o_full          (o_full),
    .o_issue_valid   (o_issue_valid),
    .o_issue_op      (o_issue_op),
    .o_issue_rd_rnid (o_issue_rd_rnid),
    .o_wb_valid      (w_wb_valid),
    .o_wb_rnid       (w_wb_rnid),
    .o_done_valid    (o_done_valid),
    .o_done_cmt_id   (o_done_cmt_id),
    .o_done_except   (o_done_except),
    .o_dead_done     (o_dead_done),
    .o_dead_cmt_id   (o_dead_cmt_id)
  );

  // latency model, fed by the picked op
  exec_timer u_timer (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_pick_vec (w_pick_vec),
    .i_pick_op  (o_issue_op),
    .i_dead     (w_dead),
    .o_done_vec (w_exec_done_vec)
  );

endmodule

// File: logic/wakeup_match.sv
`include "sched_params.svh"

module wakeup_match (
  input  logic [`RNID_W-1:0] i_rnid,
  input  logic               i_wb_valid,
  input  logic [`RNID_W-1:0] i_wb_rnid,
  input  logic               i_ext_wr_valid,
  input  logic [`RNID_W-1:0] i_ext_wr_rnid,
  output logic               o_hit
);

  logic w_wb_hit;
  logic w_ext_hit;

  // internal completion broadcast
  assign w_wb_hit = i_wb_valid & (i_wb_rnid == i_rnid);

  // external write-back, e.g. load return
  assign w_ext_hit = i_ext_wr_valid & (i_ext_wr_rnid == i_rnid);

  assign o_hit = w_wb_hit | w_ext_hit;

endmodule

// File: test/sched_chk.sv
`include "sched_params.svh"

module sched_chk (
  input logic                      i_clk,
  input logic                      i_reset_n,
  input logic                      i_commit_valid,
  input logic                      o_issue_valid,
  input sched_pkg::op_t            o_issue_op,
  input logic                      o_done_valid,
  input logic [`SCHED_ENTRIES-1:0] i_pick_vec,
  input logic [`SCHED_ENTRIES-1:0] i_issued,
  input logic [`SCHED_ENTRIES-1:0] i_done,
  input logic [`SCHED_ENTRIES-1:0] i_exec_done_vec
);

  import sched_pkg::*;

  // each picked entry reaches its own done unless a commit intervenes
  for (genvar g = 0; g < `SCHED_ENTRIES; g++) begin : g_issue_done
    a_issue_done: assert property (@(posedge i_clk) disable iff (!i_reset_n || i_commit_valid)
      i_pick_vec[g] |-> ##[1:4*`LAT_MUL] (o_done_valid && i_done[g]))
      else $error("issued op did not complete within the latency bound");
  end

  // lone MUL with nothing else in flight
  a_lat_mul: assert property (@(posedge i_clk) disable iff (!i_reset_n || i_commit_valid)
    (o_issue_valid && o_issue_op == OP_MUL && i_issued == '0 && i_done == '0) |->
    ##1 (i_exec_done_vec == '0) [*(`LAT_MUL - 1)] ##1 (i_exec_done_vec != '0))
    else $error("MUL done strobe not at its fixed latency");

  a_lat_alu: assert property (@(posedge i_clk) disable iff (!i_reset_n || i_commit_valid)
    (o_issue_valid && o_issue_op != OP_MUL && i_issued == '0 && i_done == '0) |->
    ##`LAT_ALU (i_exec_done_vec != '0))
    else $error("ALU done strobe not at its fixed latency");

endmodule

bind sched_top sched_chk u_chk (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_commit_valid  (i_commit_valid),
  .o_issue_valid   (o_issue_valid),
  .o_issue_op      (o_issue_op),
  .o_done_valid    (o_done_valid),
  .i_pick_vec      (w_pick_vec),
  .i_issued        (w_issued),
  .i_done          (w_done),
  .i_exec_done_vec (w_exec_done_vec)
);

// File: test/sched_tb.sv
`include "sched_params.svh"

module sched_tb;

  import sched_pkg::*;

  localparam int TEST_CYCLES    = 120;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;
  localparam int IDS            = 1 << `CMT_ID_W;
  localparam int TAGS           = 1 << `RNID_W;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_put;
  op_t                  i_put_op;
  logic                 i_put_rs1_valid;
  logic [`RNID_W-1:0]   i_put_rs1_rnid;
  logic                 i_put_rs2_valid;
  logic [`RNID_W-1:0]   i_put_rs2_rnid;
  logic [`RNID_W-1:0]   i_put_rd_rnid;
  logic [`CMT_ID_W-1:0] i_put_cmt_id;
  logic                 i_ext_wr_valid;
  logic [`RNID_W-1:0]   i_ext_wr_rnid;
  logic                 i_commit_valid;
  logic                 i_commit_flush;
  logic                 i_commit_all_dead;
  logic [`CMT_ID_W-1:0] i_commit_cmt_id;
  logic                 o_issue_valid;
  op_t                  o_issue_op;
  logic [`RNID_W-1:0]   o_issue_rd_rnid;
  logic                 o_done_valid;
  logic [`CMT_ID_W-1:0] o_done_cmt_id;
  logic                 o_done_except;
  logic                 o_dead_done;
  logic [`CMT_ID_W-1:0] o_dead_cmt_id;
  logic                 o_full;

  int seed = 58;
  int errors;       // from the stimulus process
  int mon_errors;   // from the monitor
  int tests_run;
  int tests_failed;
  int cycle;
  int issue_cycle;
  int done_count;
  int except_count;
  int ext_count;
  int pending_count;
  int lat_expect;   // 0 when off
  int dep_ext_base;
  logic pending [IDS];
  logic exp_except [IDS];
  logic done_seen [IDS];
  op_t  exp_op [TAGS];
  logic rd_wait [TAGS];
  logic dep_on;
  logic dep_use_ext;
  logic no_issue;
  logic [`RNID_W-1:0]   dep_rd;
  logic [`CMT_ID_W-1:0] dep_src_id;
  logic [`CMT_ID_W-1:0] next_id;
  logic [`RNID_W-1:0]   next_rd;

  sched_top i_sched_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // scoreboard and timeout on the rising edge
  always @(posedge i_clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end else if (i_reset_n) begin
      if (i_ext_wr_valid) ext_count++;
      if (o_done_valid) begin
        assert (pending[o_done_cmt_id]) else begin
          $display("completion reported for id %h that is not in flight", o_done_cmt_id);
          mon_errors++;
        end
        assert (o_done_except == exp_except[o_done_cmt_id]) else begin
          $display("FAILED o_done_except: expected %h, got %h",
                   exp_except[o_done_cmt_id], o_done_except);
          mon_errors++;
        end
        if (lat_expect != 0) begin
          assert (cycle - issue_cycle == lat_expect + 1) else begin
            $display("FAILED issue to done cycles: expected %h, got %h",
                     lat_expect + 1, cycle - issue_cycle);
            mon_errors++;
          end
        end
        if (o_done_except) except_count++;
        if (pending[o_done_cmt_id]) pending_count--;
        pending[o_done_cmt_id] = 1'b0;
        done_seen[o_done_cmt_id] = 1'b1;
        done_count++;
      end
      if (o_issue_valid) begin
        assert (rd_wait[o_issue_rd_rnid]) else begin
          $display("issue of tag %h that is not waiting to issue", o_issue_rd_rnid);
          mon_errors++;
        end
        assert (o_issue_op == exp_op[o_issue_rd_rnid]) else begin
          $display("FAILED o_issue_op: expected %h, got %h",
                   exp_op[o_issue_rd_rnid], o_issue_op);
          mon_errors++;
        end
        rd_wait[o_issue_rd_rnid] = 1'b0;
        if (dep_on && o_issue_rd_rnid == dep_rd) begin
          assert (dep_use_ext ? (ext_count > dep_ext_base) : done_seen[dep_src_id]) else begin
            $display("consumer issued before its source was written");
            mon_errors++;
          end
        end
        assert (!no_issue) else begin
          $display("an op issued while its source tag was still unwritten");
          mon_errors++;
        end
        issue_cycle = cycle;
      end
      if (i_commit_valid && i_commit_flush) begin
        for (int i = 0; i < IDS; i++) pending[i] = 1'b0;
        pending_count = 0;
      end
      if (i_put && !o_full) begin
        pending[i_put_cmt_id] = 1'b1;
        exp_except[i_put_cmt_id] = (i_put_op == OP_TRAP);
        done_seen[i_put_cmt_id] = 1'b0;
        exp_op[i_put_rd_rnid] = i_put_op;
        rd_wait[i_put_rd_rnid] = 1'b1;
        pending_count++;
      end
    end
  end

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic put_op(input op_t op, input logic rs1v, input logic [`RNID_W-1:0] rs1,
                        input logic rs2v, input logic [`RNID_W-1:0] rs2);
    i_put = 1'b1;
    i_put_op = op;
    i_put_rs1_valid = rs1v;
    i_put_rs1_rnid = rs1;
    i_put_rs2_valid = rs2v;
    i_put_rs2_rnid = rs2;
    i_put_rd_rnid = next_rd;
    i_put_cmt_id = next_id;
    @(negedge i_clk);
    i_put = 1'b0;
    i_put_rs1_valid = 1'b0;
    i_put_rs2_valid = 1'b0;
    next_id = next_id + `CMT_ID_W'(1);
    next_rd = next_rd + `RNID_W'(1);
  endtask

  task automatic wait_idle();
    while (pending_count != 0) @(negedge i_clk);
    repeat (2) @(negedge i_clk);
  endtask

  task automatic ext_pulse(input logic [`RNID_W-1:0] tag);
    i_ext_wr_valid = 1'b1;
    i_ext_wr_rnid = tag;
    @(negedge i_clk);
    i_ext_wr_valid = 1'b0;
  endtask

  task automatic flush_all();
    i_commit_valid = 1'b1;
    i_commit_flush = 1'b1;
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    i_commit_flush = 1'b0;
  endtask

  task automatic retire_dead(input logic [`CMT_ID_W-1:0] id);
    i_commit_valid = 1'b1;
    i_commit_all_dead = 1'b1;
    i_commit_cmt_id = id;
    @(posedge i_clk);
    check_value("o_dead_done", 1, int'(o_dead_done));
    check_value("o_dead_cmt_id", int'(id), int'(o_dead_cmt_id));
    @(negedge i_clk);
    i_commit_valid = 1'b0;
    i_commit_all_dead = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors + mon_errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL", name);
    end
  endtask

  initial begin
    int rnd;
    int e0;
    int d0;
    logic [`RNID_W-1:0] tag;
    logic [`RNID_W-1:0] prod_rd;
    logic [`CMT_ID_W-1:0] rid;

    i_reset_n = 1'b0;
    i_put = 1'b0;
    i_put_op = OP_ADD;
    i_put_rs1_valid = 1'b0;
    i_put_rs1_rnid = '0;
    i_put_rs2_valid = 1'b0;
    i_put_rs2_rnid = '0;
    i_put_rd_rnid = '0;
    i_put_cmt_id = '0;
    i_ext_wr_valid = 1'b0;
    i_ext_wr_rnid = '0;
    i_commit_valid = 1'b0;
    i_commit_flush = 1'b0;
    i_commit_all_dead = 1'b0;
    i_commit_cmt_id = '0;
    dep_on = 1'b0;
    dep_use_ext = 1'b0;
    no_issue = 1'b0;
    lat_expect = 0;
    for (int i = 0; i < IDS; i++) begin
      pending[i] = 1'b0;
      exp_except[i] = 1'b0;
      done_seen[i] = 1'b0;
    end
    for (int i = 0; i < TAGS; i++) begin
      exp_op[i] = OP_ADD;
      rd_wait[i] = 1'b0;
    end
    rnd = $random(seed);
    next_id = rnd[`CMT_ID_W-1:0];
    rnd = $random(seed);
    next_rd = rnd[`RNID_W-1:0];
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // independent sourceless ops
    e0 = errors + mon_errors;
    d0 = done_count;
    put_op(OP_ADD, 1'b0, '0, 1'b0, '0);
    put_op(OP_SUB, 1'b0, '0, 1'b0, '0);
    put_op(OP_XOR, 1'b0, '0, 1'b0, '0);
    put_op(OP_TRAP, 1'b0, '0, 1'b0, '0);
    wait_idle();
    check_value("done count", 4, done_count - d0);
    end_test("independent", e0);

    // producer to consumer
    e0 = errors + mon_errors;
    prod_rd = next_rd;
    dep_src_id = next_id;
    dep_rd = next_rd + `RNID_W'(1);
    dep_use_ext = 1'b0;
    dep_on = 1'b1;
    put_op(OP_ADD, 1'b0, '0, 1'b0, '0);
    put_op(OP_XOR, 1'b1, prod_rd, 1'b0, '0);
    wait_idle();
    // source held on an external tag
    tag = next_rd + `RNID_W'(16);
    dep_rd = next_rd;
    dep_use_ext = 1'b1;
    dep_ext_base = ext_count;
    put_op(OP_SUB, 1'b0, '0, 1'b1, tag);
    repeat (3) @(negedge i_clk);
    ext_pulse(tag);
    wait_idle();
    dep_on = 1'b0;
    end_test("dependency", e0);

    e0 = errors + mon_errors;
    lat_expect = `LAT_MUL;
    put_op(OP_MUL, 1'b0, '0, 1'b0, '0);
    wait_idle();
    lat_expect = `LAT_ALU;
    put_op(OP_ADD, 1'b0, '0, 1'b0, '0);
    wait_idle();
    lat_expect = 0;
    end_test("latency", e0);

    e0 = errors + mon_errors;
    d0 = except_count;
    put_op(OP_TRAP, 1'b0, '0, 1'b0, '0);
    put_op(OP_ADD, 1'b0, '0, 1'b0, '0);
    wait_idle();
    check_value("exception count", 1, except_count - d0);
    end_test("exception", e0);

    // four waiting ops flushed and retired one id at a time
    e0 = errors + mon_errors;
    d0 = done_count;
    tag = next_rd + `RNID_W'(16);
    rid = next_id;
    repeat (4) put_op(OP_SUB, 1'b1, tag, 1'b0, '0);
    check_value("o_full", 1, int'(o_full));
    flush_all();
    repeat (3) @(negedge i_clk);
    repeat (4) begin
      retire_dead(rid);
      rid = rid + `CMT_ID_W'(1);
    end
    check_value("o_full", 0, int'(o_full));
    check_value("done count", 0, done_count - d0);
    end_test("flush", e0);

    e0 = errors + mon_errors;
    d0 = done_count;
    tag = next_rd + `RNID_W'(16);
    no_issue = 1'b1;
    repeat (4) put_op(OP_ADD, 1'b1, tag, 1'b0, '0);
    check_value("o_full", 1, int'(o_full));
    put_op(OP_XOR, 1'b1, tag, 1'b0, '0);
    repeat (4) @(negedge i_clk);
    no_issue = 1'b0;
    ext_pulse(tag);
    wait_idle();
    check_value("done count", 4, done_count - d0);
    end_test("full", e0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + mon_errors);
    if (errors + mon_errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
